// File: layer_ctrl.f
logic/layer_ctrl_pkg.sv
logic/layer_code_rom.sv
logic/layer_fsm.sv
logic/ifmap_streamer.sv
logic/ofmap_writer.sv
logic/layer_ctrl_top.sv
sim/layer_ctrl_properties.sv
sim/layer_ctrl_tb.sv

// File: sim/layer_ctrl_tb.sv
//########################################
// layer controller testbench with clock, reset, ram and array models
// lfsr stimulus, reference model and its checks
//########################################

`timescale 1ns/1ps

module layer_ctrl_tb import layer_ctrl_pkg::*; ();

    localparam int RAM_DEPTH = 2 ** RAM_ADDR_W;
    localparam int RUNS      = 2;
    localparam int CMP_W     = $bits(layer_code_t);

    typedef struct packed {
        logic        last;
        spike_word_t data;
    } beat_t;

    typedef struct packed {
        logic        bank;
        ram_addr_t   addr;
        spike_word_t data;
    } wr_t;

    logic        s_clk = 1'b0;
    logic        s_rst;
    logic        i_start;
    logic        o_code_valid;
    layer_code_t o_layer_code;
    logic        o_net_done;
    logic        o_ram0_wea;
    ram_addr_t   o_ram0_addra;
    spike_word_t o_ram0_dina;
    ram_addr_t   o_ram0_addrb;
    spike_word_t i_ram0_doutb;
    logic        o_ram1_wea;
    ram_addr_t   o_ram1_addra;
    spike_word_t o_ram1_dina;
    ram_addr_t   o_ram1_addrb;
    spike_word_t i_ram1_doutb;
    logic        o_ifmap_valid;
    spike_word_t o_ifmap_data;
    logic        o_ifmap_last;
    logic        i_ifmap_ready;
    logic        i_array_valid;
    spike_word_t i_array_data;
    logic        i_array_done;
    logic        o_array_ready;

    // ram models and the reference copy of both banks
    spike_word_t ram_bank [2][RAM_DEPTH];
    spike_word_t ref_mem [2][RAM_DEPTH];
    ram_addr_t   rd_addr_q [2];

    beat_t       exp_beats [$];
    wr_t         exp_writes [$];
    beat_t       beat_now;
    wr_t         wr_now;
    layer_code_t cur_code;
    logic        rd_bank;
    logic        wr_bank;
    ram_addr_t   ref_wr_addr;
    logic [15:0] lfsr_state = 16'd6;
    int          layer_total = 0;
    int          layers_in_run = 0;
    int          done_cnt = 0;
    int          arr_left = 0;
    int          done_req = 0;
    int          done_sent = 0;
    int          cycle_cnt = 0;
    int          cycle_limit;

    layer_ctrl_top UUT (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_start       (i_start),
        .o_code_valid  (o_code_valid),
        .o_layer_code  (o_layer_code),
        .o_net_done    (o_net_done),
        .o_ram0_wea    (o_ram0_wea),
        .o_ram0_addra  (o_ram0_addra),
        .o_ram0_dina   (o_ram0_dina),
        .o_ram0_addrb  (o_ram0_addrb),
        .i_ram0_doutb  (i_ram0_doutb),
        .o_ram1_wea    (o_ram1_wea),
        .o_ram1_addra  (o_ram1_addra),
        .o_ram1_dina   (o_ram1_dina),
        .o_ram1_addrb  (o_ram1_addrb),
        .i_ram1_doutb  (i_ram1_doutb),
        .o_ifmap_valid (o_ifmap_valid),
        .o_ifmap_data  (o_ifmap_data),
        .o_ifmap_last  (o_ifmap_last),
        .i_ifmap_ready (i_ifmap_ready),
        .i_array_valid (i_array_valid),
        .i_array_data  (i_array_data),
        .i_array_done  (i_array_done),
        .o_array_ready (o_array_ready)
    );

    bind layer_ctrl_top layer_ctrl_properties u_props (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_code_valid  (o_code_valid),
        .i_ifmap_valid (o_ifmap_valid),
        .i_ifmap_data  (o_ifmap_data),
        .i_ifmap_last  (o_ifmap_last),
        .i_ifmap_ready (i_ifmap_ready),
        .i_array_ready (o_array_ready)
    );

    always #2 s_clk = ~s_clk;

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    function automatic spike_word_t fill_word(input logic bank, input ram_addr_t a);
        return {7'h5a, bank, 11'h0, a};
    endfunction

    // ifmap beats plus array beats of one run
    function automatic int beats_per_run();
        int total;
        int l;
        total = 0;
        for (l = 0; l < LAYER_NUM; l++) begin
            total += int'(LAYER_TABLE[l].out_ch) * (int'(LAYER_TABLE[l].img_size)
                   * (int'(LAYER_TABLE[l].in_ch) / PE_NUM * KERNEL_ROWS + 1));
        end
        return total;
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        abort_run();
    endtask

    task automatic compare(input string what, input logic [CMP_W-1:0] got,
                           input logic [CMP_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // beats in group, output row and window row order with source row r+k-1
    task automatic predict_layer(input layer_code_t code, input logic bank);
        int    grp_num;
        int    img;
        int    p;
        int    g;
        int    r;
        int    k;
        int    src;
        beat_t b;
        grp_num = int'(code.in_ch) / PE_NUM;
        img     = int'(code.img_size);
        for (p = 0; p < int'(code.out_ch); p++) begin
            for (g = 0; g < grp_num; g++) begin
                for (r = 0; r < img; r++) begin
                    for (k = 0; k < KERNEL_ROWS; k++) begin
                        src    = r + k - 1;
                        b.last = (g == grp_num - 1) && (r == img - 1) && (k == KERNEL_ROWS - 1);
                        if (src < 0 || src >= img) begin
                            b.data = '0;
                        end else begin
                            b.data = ref_mem[bank][g * img + src];
                        end
                        exp_beats.push_back(b);
                    end
                end
            end
        end
    endtask

    task automatic preload_banks();
        int a;
        int words;
        words = int'(LAYER_TABLE[0].in_ch) / PE_NUM * int'(LAYER_TABLE[0].img_size);
        for (a = 0; a < RAM_DEPTH; a++) begin
            ram_bank[0][a] = fill_word(1'b0, ram_addr_t'(a));
            ram_bank[1][a] = fill_word(1'b1, ram_addr_t'(a));
            ref_mem[0][a]  = ram_bank[0][a];
            ref_mem[1][a]  = ram_bank[1][a];
        end
        for (a = 0; a < words; a++) begin
            ram_bank[0][a] = rand_bits(32);
            ref_mem[0][a]  = ram_bank[0][a];
        end
    endtask

    // writes land at the edge and read data follows the address by one cycle
    always @(posedge s_clk) begin
        if (o_ram0_wea) begin
            ram_bank[0][o_ram0_addra] <= o_ram0_dina;
        end
        if (o_ram1_wea) begin
            ram_bank[1][o_ram1_addra] <= o_ram1_dina;
        end
        rd_addr_q[0] <= o_ram0_addrb;
        rd_addr_q[1] <= o_ram1_addrb;
    end

    // stimulus and array model on the falling edge
    always @(negedge s_clk) begin
        i_ifmap_ready = rand_bit();
        i_array_done  = 1'b0;
        if (done_req != done_sent) begin
            i_array_valid = 1'b0;
            i_array_done  = 1'b1;
            done_sent++;
        end else if (arr_left > 0) begin
            i_array_valid = rand_bit();
            i_array_data  = rand_bits(32);
        end else begin
            i_array_valid = 1'b0;
        end
        i_ram0_doutb = ram_bank[0][rd_addr_q[0]];
        i_ram1_doutb = ram_bank[1][rd_addr_q[1]];
    end

    always @(posedge s_clk) begin
        if (!s_rst) begin
            if (o_code_valid) begin
                cur_code = LAYER_TABLE[layer_total % LAYER_NUM];
                compare("layer code", o_layer_code, cur_code);
                // read bank alternates layer by layer across runs
                rd_bank     = layer_total[0];
                wr_bank     = ~rd_bank;
                ref_wr_addr = '0;
                predict_layer(cur_code, rd_bank);
                layer_total++;
                layers_in_run++;
            end
            if (o_ifmap_valid && i_ifmap_ready) begin
                if (exp_beats.size() == 0) begin
                    report_failure("ifmap beat accepted with no beat predicted");
                end else begin
                    beat_now = exp_beats.pop_front();
                    compare("ifmap data", o_ifmap_data, beat_now.data);
                    compare("ifmap last", o_ifmap_last, beat_now.last);
                    if (o_ifmap_last) begin
                        arr_left = int'(cur_code.img_size);
                    end
                end
            end
            if (i_array_valid && o_array_ready) begin
                wr_now.bank = wr_bank;
                wr_now.addr = ref_wr_addr;
                wr_now.data = i_array_data;
                exp_writes.push_back(wr_now);
                ref_mem[wr_bank][ref_wr_addr] = i_array_data;
                ref_wr_addr++;
                arr_left--;
                if (arr_left == 0) begin
                    done_req++;
                end
            end
            if (o_ram0_wea || o_ram1_wea) begin
                if (o_ram0_wea && o_ram1_wea) begin
                    report_failure("both banks written in the same cycle");
                end else if (exp_writes.size() == 0) begin
                    report_failure("ram write with no accepted array beat behind it");
                end else begin
                    wr_now = exp_writes.pop_front();
                    compare("write bank", o_ram1_wea, wr_now.bank);
                    compare("write address", o_ram1_wea ? o_ram1_addra : o_ram0_addra,
                            wr_now.addr);
                    compare("write data", o_ram1_wea ? o_ram1_dina : o_ram0_dina,
                            wr_now.data);
                end
            end
            if (o_net_done) begin
                compare("layers in run", layers_in_run, LAYER_NUM);
                compare("ifmap beats left at net done", exp_beats.size(), 0);
                compare("writes left at net done", exp_writes.size(), 0);
                layers_in_run = 0;
                done_cnt++;
            end
        end
    end

    always @(posedge s_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the runs did not finish within %0d cycles", cycle_limit);
            abort_run();
        end else if (UUT.u_props.fail_cnt != 0) begin
            report_failure("A handshake assertion on the DUT failed");
        end
    end

    initial begin
        int run;
        s_rst         = 1'b1;
        i_start       = 1'b0;
        i_ifmap_ready = 1'b0;
        i_array_valid = 1'b0;
        i_array_data  = '0;
        i_array_done  = 1'b0;
        i_ram0_doutb  = '0;
        i_ram1_doutb  = '0;
        cycle_limit   = 8 * RUNS * beats_per_run();
        preload_banks();
        repeat (5) @(negedge s_clk);
        s_rst = 1'b0;
        for (run = 0; run < RUNS; run++) begin
            @(negedge s_clk);
            i_start = 1'b1;
            @(negedge s_clk);
            i_start = 1'b0;
            wait (done_cnt == run + 1);
        end
        repeat (4) @(negedge s_clk);
        if (UUT.u_props.fail_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            report_failure("A handshake assertion on the DUT failed");
        end
    end

endmodule

// File: sim/layer_ctrl_properties.sv
//########################################
// handshake assertions, bound into the controller top
//########################################

`timescale 1ns/1ps

module layer_ctrl_properties import layer_ctrl_pkg::*; (
    input logic        s_clk,
    input logic        s_rst,
    input logic        i_code_valid,
    input logic        i_ifmap_valid,
    input spike_word_t i_ifmap_data,
    input logic        i_ifmap_last,
    input logic        i_ifmap_ready,
    input logic        i_array_ready
);

    int fail_cnt = 0;

    // a stalled beat holds until the array takes it
    a_ifmap_hold: assert property (
        @(posedge s_clk) disable iff (s_rst)
        (i_ifmap_valid && !i_ifmap_ready) |=>
            (i_ifmap_valid && $stable(i_ifmap_data) && $stable(i_ifmap_last))
    ) else begin
        $error("ifmap beat changed while stalled");
        fail_cnt++;
    end

    a_send_collect_excl: assert property (
        @(posedge s_clk) disable iff (s_rst)
        !(i_ifmap_valid && i_array_ready)
    ) else begin
        $error("ifmap valid and array ready high together");
        fail_cnt++;
    end

    a_code_pulse: assert property (
        @(posedge s_clk) disable iff (s_rst)
        i_code_valid |=> !i_code_valid
    ) else begin
        $error("code valid held longer than one cycle");
        fail_cnt++;
    end

endmodule

// File: logic/layer_ctrl_top.sv
//######################################
// layer controller top: code rom, fsm, streamer, writer
//######################################

`timescale 1ns/1ps

module layer_ctrl_top import layer_ctrl_pkg::*; (
    input  logic        s_clk,
    input  logic        s_rst,
    input  logic        i_start,
    output logic        o_code_valid,
    output layer_code_t o_layer_code,
    output logic        o_net_done,
    // bank 0
    output logic        o_ram0_wea,
    output ram_addr_t   o_ram0_addra,
    output spike_word_t o_ram0_dina,
    output ram_addr_t   o_ram0_addrb,
    input  spike_word_t i_ram0_doutb,
    // bank 1
    output logic        o_ram1_wea,
    output ram_addr_t   o_ram1_addra,
    output spike_word_t o_ram1_dina,
    output ram_addr_t   o_ram1_addrb,
    input  spike_word_t i_ram1_doutb,
    // to the PE array
    output logic        o_ifmap_valid,
    output spike_word_t o_ifmap_data,
    output logic        o_ifmap_last,
    input  logic        i_ifmap_ready,
    // from the PE array
    input  logic        i_array_valid,
    input  spike_word_t i_array_data,
    input  logic        i_array_done,
    output logic        o_array_ready
);

    logic        rom_valid;
    logic        rom_ready;
    layer_code_t rom_code;
    logic        rom_last;
    logic        bank_sel;
    logic        start_pass;
    logic        pass_sent;
    logic        collect;

    layer_code_rom u_layer_code_rom (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_code_ready (rom_ready),
        .o_code_valid (rom_valid),
        .o_code       (rom_code),
        .o_last       (rom_last)
    );

    layer_fsm u_layer_fsm (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_start      (i_start),
        .i_code_valid (rom_valid),
        .i_code       (rom_code),
        .i_code_last  (rom_last),
        .i_pass_sent  (pass_sent),
        .i_array_done (i_array_done),
        .o_code_ready (rom_ready),
        .o_code_valid (o_code_valid),
        .o_layer_code (o_layer_code),
        .o_bank_sel   (bank_sel),
        .o_start_pass (start_pass),
        .o_collect    (collect),
        .o_net_done   (o_net_done)
    );

    ifmap_streamer u_ifmap_streamer (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_start_pass  (start_pass),
        .i_code        (o_layer_code),
        .i_bank_sel    (bank_sel),
        .i_ram0_doutb  (i_ram0_doutb),
        .i_ram1_doutb  (i_ram1_doutb),
        .i_ifmap_ready (i_ifmap_ready),
        .o_ram0_addrb  (o_ram0_addrb),
        .o_ram1_addrb  (o_ram1_addrb),
        .o_ifmap_valid (o_ifmap_valid),
        .o_ifmap_data  (o_ifmap_data),
        .o_ifmap_last  (o_ifmap_last),
        .o_pass_sent   (pass_sent)
    );

    ofmap_writer u_ofmap_writer (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_collect     (collect),
        .i_bank_sel    (bank_sel),
        .i_array_valid (i_array_valid),
        .i_array_data  (i_array_data),
        .o_array_ready (o_array_ready),
        .o_ram0_wea    (o_ram0_wea),
        .o_ram0_addra  (o_ram0_addra),
        .o_ram0_dina   (o_ram0_dina),
        .o_ram1_wea    (o_ram1_wea),
        .o_ram1_addra  (o_ram1_addra),
        .o_ram1_dina   (o_ram1_dina)
    );

endmodule

// File: logic/ofmap_writer.sv
//######################################
// array output write-back to the write bank
//######################################

`timescale 1ns/1ps

module ofmap_writer import layer_ctrl_pkg::*; (
    input  logic        s_clk,
    input  logic        s_rst,
    input  logic        i_collect,
    input  logic        i_bank_sel,
    input  logic        i_array_valid,
    input  spike_word_t i_array_data,
    output logic        o_array_ready,
    output logic        o_ram0_wea,
    output ram_addr_t   o_ram0_addra,
    output spike_word_t o_ram0_dina,
    output logic        o_ram1_wea,
    output ram_addr_t   o_ram1_addra,
    output spike_word_t o_ram1_dina
);

    logic        wr_en;
    ram_addr_t   wr_addr;
    spike_word_t wr_data;
    logic        bank_sel_d;

    assign o_array_ready = i_collect;

    // bank_sel reads bank 0 when low, so bank 1 takes the writes
    assign o_ram0_wea   = i_bank_sel ? wr_en : 1'b0;
    assign o_ram0_addra = i_bank_sel ? wr_addr : '0;
    assign o_ram0_dina  = i_bank_sel ? wr_data : '0;
    assign o_ram1_wea   = i_bank_sel ? 1'b0 : wr_en;
    assign o_ram1_addra = i_bank_sel ? '0 : wr_addr;
    assign o_ram1_dina  = i_bank_sel ? '0 : wr_data;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_en      <= 1'b0;
            wr_addr    <= '0;
            bank_sel_d <= 1'b0;
        end else begin
            wr_en      <= o_array_ready && i_array_valid;
            bank_sel_d <= i_bank_sel;
            // new layer restarts at address 0
            if (i_bank_sel != bank_sel_d) begin
                wr_addr <= '0;
            end else if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (o_array_ready && i_array_valid) begin
            wr_data <= i_array_data;
        end
    end

endmodule

// File: logic/ifmap_streamer.sv
//######################################
// padded 3-row window reads from the read bank
// 2-entry beat buffer for back-pressure
//######################################

`timescale 1ns/1ps

module ifmap_streamer import layer_ctrl_pkg::*; (
    input  logic        s_clk,
    input  logic        s_rst,
    input  logic        i_start_pass,
    input  layer_code_t i_code,
    input  logic        i_bank_sel,
    input  spike_word_t i_ram0_doutb,
    input  spike_word_t i_ram1_doutb,
    input  logic        i_ifmap_ready,
    output ram_addr_t   o_ram0_addrb,
    output ram_addr_t   o_ram1_addrb,
    output logic        o_ifmap_valid,
    output spike_word_t o_ifmap_data,
    output logic        o_ifmap_last,
    output logic        o_pass_sent
);

    typedef struct packed {
        logic        last;
        spike_word_t data;
    } ifmap_beat_t;

    // walk position: group, output row, window row
    code_field_t grp_cnt;
    code_field_t row_cnt;
    logic [1:0]  win_cnt;
    code_field_t grp_base;
    code_field_t src_row_p1;
    code_field_t addr_full;
    code_field_t grp_num;
    ram_addr_t   rd_addr;
    logic        active;
    logic        pad_row;
    logic        walk_last;
    logic        slot_free;
    logic        issue;

    // read in flight, tags travel alongside it
    logic        pend;
    logic        pend_pad;
    logic        pend_last;
    spike_word_t rd_word;
    ifmap_beat_t push_beat;

    ifmap_beat_t fifo_mem [2];
    logic        wr_ptr;
    logic        rd_ptr;
    logic [1:0]  occ;
    logic        pop;

    assign grp_num    = i_code.in_ch >> $clog2(PE_NUM);
    // source row plus one, so row -1 becomes 0
    assign src_row_p1 = row_cnt + code_field_t'(win_cnt);
    assign pad_row    = (src_row_p1 == '0) || (src_row_p1 > i_code.img_size);
    assign addr_full  = grp_base + src_row_p1 - code_field_t'(1);
    assign rd_addr    = addr_full[RAM_ADDR_W-1:0];

    assign walk_last = (grp_cnt == grp_num - code_field_t'(1))
                    && (row_cnt == i_code.img_size - code_field_t'(1))
                    && (win_cnt == 2'(KERNEL_ROWS - 1));

    assign pop       = o_ifmap_valid && i_ifmap_ready;
    assign slot_free = (occ == 2'd0) || ((occ == 2'd1) && !pend) || pop;
    assign issue     = active && slot_free;

    assign o_ram0_addrb = i_bank_sel ? '0 : rd_addr;
    assign o_ram1_addrb = i_bank_sel ? rd_addr : '0;
    assign rd_word      = i_bank_sel ? i_ram1_doutb : i_ram0_doutb;

    assign push_beat.last = pend_last;
    assign push_beat.data = pend_pad ? '0 : rd_word;

    assign o_ifmap_valid = (occ != 2'd0);
    assign o_ifmap_data  = fifo_mem[rd_ptr].data;
    assign o_ifmap_last  = fifo_mem[rd_ptr].last;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            active   <= 1'b0;
            grp_cnt  <= '0;
            row_cnt  <= '0;
            win_cnt  <= '0;
            grp_base <= '0;
        end else if (i_start_pass) begin
            active   <= 1'b1;
            grp_cnt  <= '0;
            row_cnt  <= '0;
            win_cnt  <= '0;
            grp_base <= '0;
        end else if (issue) begin
            if (walk_last) begin
                active <= 1'b0;
            end
            if (win_cnt == 2'(KERNEL_ROWS - 1)) begin
                win_cnt <= '0;
                if (row_cnt == i_code.img_size - code_field_t'(1)) begin
                    row_cnt  <= '0;
                    grp_cnt  <= grp_cnt + code_field_t'(1);
                    grp_base <= grp_base + i_code.img_size;
                end else begin
                    row_cnt <= row_cnt + code_field_t'(1);
                end
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            pend        <= 1'b0;
            occ         <= '0;
            wr_ptr      <= 1'b0;
            rd_ptr      <= 1'b0;
            o_pass_sent <= 1'b0;
        end else begin
            pend        <= issue;
            o_pass_sent <= pop && o_ifmap_last;
            if (pend) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({pend, pop})
                2'b10:   occ <= occ + 2'd1;
                2'b01:   occ <= occ - 2'd1;
                default: occ <= occ;
            endcase
        end
    end

    always_ff @(posedge s_clk) begin
        pend_pad  <= pad_row;
        pend_last <= walk_last;
        if (pend) begin
            fifo_mem[wr_ptr] <= push_beat;
        end
    end

endmodule

// File: logic/layer_fsm.sv
//######################################
// layer sequencer: fetch, bank switch, send/collect passes
//######################################

`timescale 1ns/1ps

module layer_fsm import layer_ctrl_pkg::*; (
    input  logic        s_clk,
    input  logic        s_rst,
    input  logic        i_start,
    input  logic        i_code_valid,
    input  layer_code_t i_code,
    input  logic        i_code_last,
    input  logic        i_pass_sent,
    input  logic        i_array_done,
    output logic        o_code_ready,
    output logic        o_code_valid,
    output layer_code_t o_layer_code,
    output logic        o_bank_sel,
    output logic        o_start_pass,
    output logic        o_collect,
    output logic        o_net_done
);

    fsm_state_t  state;
    fsm_state_t  state_next;
    code_field_t pass_cnt;
    logic        last_layer;
    logic        code_xfer;
    logic        final_pass;

    assign o_code_ready = (state == ST_FETCH);
    assign code_xfer    = i_code_valid && o_code_ready;
    assign final_pass   = (pass_cnt == o_layer_code.out_ch - code_field_t'(1));
    assign o_collect    = (state == ST_COLLECT);
    assign o_net_done   = (state == ST_DONE);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:    if (i_start) state_next = ST_FETCH;
            ST_FETCH:   if (code_xfer) state_next = ST_SWITCH;
            ST_SWITCH:  state_next = ST_SEND;
            ST_SEND:    if (i_pass_sent) state_next = ST_COLLECT;
            ST_COLLECT: begin
                if (i_array_done) begin
                    if (!final_pass) begin
                        state_next = ST_SEND;
                    end else if (last_layer) begin
                        state_next = ST_DONE;
                    end else begin
                        state_next = ST_FETCH;
                    end
                end
            end
            ST_DONE:    state_next = ST_IDLE;
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state        <= ST_IDLE;
            o_code_valid <= 1'b0;
            o_start_pass <= 1'b0;
        end else begin
            state        <= state_next;
            o_code_valid <= code_xfer;
            // one pulse on every entry to send
            o_start_pass <= (state_next == ST_SEND) && (state != ST_SEND);
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_layer_code <= '0;
            last_layer   <= 1'b0;
        end else if (code_xfer) begin
            o_layer_code <= i_code;
            last_layer   <= i_code_last;
        end
    end

    // output channel passes of the current layer
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            pass_cnt <= '0;
        end else if (state == ST_SWITCH) begin
            pass_cnt <= '0;
        end else if (o_collect && i_array_done && !final_pass) begin
            pass_cnt <= pass_cnt + code_field_t'(1);
        end
    end

    // written bank becomes the read bank of the next layer
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_bank_sel <= 1'b0;
        end else if (o_collect && i_array_done && final_pass) begin
            o_bank_sel <= ~o_bank_sel;
        end
    end

endmodule

// File: logic/layer_code_rom.sv
//######################################
// layer code source: index counter over the layer table
//######################################

`timescale 1ns/1ps

module layer_code_rom import layer_ctrl_pkg::*; (
    input  logic        s_clk,
    input  logic        s_rst,
    input  logic        i_code_ready,
    output logic        o_code_valid,
    output layer_code_t o_code,
    output logic        o_last
);

    layer_idx_t layer_idx;
    logic       code_xfer;

    assign code_xfer = o_code_valid && i_code_ready;

    assign o_code = LAYER_TABLE[layer_idx];
    assign o_last = (layer_idx == layer_idx_t'(LAYER_NUM - 1));

    // table is always ready once out of reset
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_code_valid <= 1'b0;
        end else begin
            o_code_valid <= 1'b1;
        end
    end

    // rewind after the final layer so the next run starts at layer 0
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            layer_idx <= '0;
        end else if (code_xfer) begin
            if (o_last) begin
                layer_idx <= '0;
            end else begin
                layer_idx <= layer_idx + 1'b1;
            end
        end
    end

endmodule

// File: logic/layer_ctrl_pkg.sv
//######################################
// shared widths, word and address types
// fsm state enum, layer code struct, layer table
//######################################

package layer_ctrl_pkg;

    // image and array geometry
    localparam int IMG_WIDTH   = 8;
    localparam int TIME_STEPS  = 4;
    localparam int PE_NUM      = 4;
    localparam int KERNEL_ROWS = 3;

    localparam int RAM_ADDR_W  = 13;
    localparam int FIELD_W     = 16;

    localparam int LAYER_NUM   = 3;
    localparam int LAYER_IDX_W = $clog2(LAYER_NUM);

    // one ram word holds a full image row for every time step
    typedef logic [IMG_WIDTH*TIME_STEPS-1:0] spike_word_t;
    typedef logic [RAM_ADDR_W-1:0]           ram_addr_t;
    typedef logic [FIELD_W-1:0]              code_field_t;
    typedef logic [LAYER_IDX_W-1:0]          layer_idx_t;

    typedef struct packed {
        code_field_t in_ch;
        code_field_t out_ch;
        code_field_t img_size;
        code_field_t lif_thrd;
        code_field_t bias_scale;
    } layer_code_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_SWITCH,
        ST_SEND,
        ST_COLLECT,
        ST_DONE
    } fsm_state_t;

    // in_ch / PE_NUM of each layer matches out_ch of the layer before
    localparam layer_code_t LAYER_TABLE [LAYER_NUM] = '{
        '{
            in_ch:      16'd4,
            out_ch:     16'd2,
            img_size:   16'd6,
            lif_thrd:   16'd12,
            bias_scale: 16'd3
        },
        '{
            in_ch:      16'd8,
            out_ch:     16'd3,
            img_size:   16'd6,
            lif_thrd:   16'd20,
            bias_scale: 16'd5
        },
        '{
            in_ch:      16'd12,
            out_ch:     16'd1,
            img_size:   16'd6,
            lif_thrd:   16'd9,
            bias_scale: 16'd2
        }
    };

endpackage
